// File: verilog.f
+incdir+include
logic/dump_pkg.sv
logic/word_stream_if.sv
logic/dump_regs.sv
logic/spi_flash_reader.sv
logic/byte_sequencer.sv
logic/uart_tx.sv
logic/flash_dump.sv
testbench/spi_flash_model.sv
testbench/flash_dump_checker.sv
testbench/tb_flash_dump.sv

// File: testbench/tb_flash_dump.sv
`timescale 1ns/1ns

module tb_flash_dump import dump_pkg::*; ();

   logic        clk = 1'b0;
   logic        rst = 1'b1;
   logic        wb_cyc = 1'b0;
   logic        wb_stb = 1'b0;
   logic        wb_we = 1'b0;
   logic [3:0]  wb_adr = '0;
   logic [31:0] wb_dat_w = '0;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   logic        spi_sck;
   logic        spi_ss;
   logic        spi_mosi;
   logic        spi_miso;
   logic        uart_tx;
   int          errors = 0;
   logic [31:0] rng = 32'h6f30_a53a;

   always #50 clk = ~clk;

   flash_dump #(.spi_div(2)) u_dut (
      .clk(clk), .rst(rst),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .spi_sck(spi_sck), .spi_ss(spi_ss), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
      .uart_tx(uart_tx)
   );

   spi_flash_model u_flash (
      .spi_sck(spi_sck), .spi_ss(spi_ss), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
   );

   flash_dump_checker u_chk (.clk(clk), .rst(rst), .uart_line(uart_tx));

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      return s ^ (s << 5);
   endfunction

   task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int t;
      int acks;
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      acks = 0;
      t    = 0;
      rdat = '0;
      while (acks == 0 && t < 20) begin
         @(negedge clk);
         t++;
         if (wb_ack) begin
            acks++;
            rdat = wb_dat_r;
         end
      end
      if (acks == 0) begin
         errors++;
         $display("wishbone access to offset %h was never acknowledged", adr);
      end else begin
         @(negedge clk);   // stb still up here
         if (wb_ack) begin
            errors++;
            $display("wishbone ack at offset %h stayed high for a second cycle", adr);
         end
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      wb_access(1'b1, adr, dat, unused);
   endtask

   task automatic check_reg(input string name, input logic [3:0] adr, input logic [31:0] exp);
      logic [31:0] v;
      wb_access(1'b0, adr, '0, v);
      if (v !== exp) begin
         errors++;
         $display("error %s expected %h actual %h", name, exp, v);
      end
   endtask

   task automatic wait_idle(input string name);
      logic [31:0] v;
      int          t;
      v = 32'd1;
      t = 0;
      while (v[0] && t < 20000) begin
         wb_access(1'b0, reg_ctrl, '0, v);
         t++;
      end
      if (v[0]) begin
         errors++;
         $display("%s: busy never cleared", name);
      end
   endtask

   task automatic wait_bytes(input string name, input int n);
      int t;
      t = 0;
      while (u_chk.rx_count < n && t < 50000) begin
         @(negedge clk);
         t++;
      end
      if (u_chk.rx_count < n) begin
         errors++;
         $display("%s: timed out waiting for uart bytes", name);
      end
   endtask

   task automatic run_dump(input string name, input logic [23:0] addr, input int len,
                           input int div, input bit restart);
      wb_write(reg_baud, 32'(div));
      wb_write(reg_addr, 32'(addr));
      wb_write(reg_len, 32'(len));
      u_chk.begin_test(name, addr, div);
      wb_write(reg_ctrl, 32'd1);
      if (restart) begin
         wait_bytes(name, 4 * len - 4);   // reader done while the uart still sends
         wb_write(reg_ctrl, 32'd1);   // must be ignored
      end
      wait_idle(name);
      wait_bytes(name, 4 * len);
      repeat (30 * div) @(negedge clk);   // room for any extra frame
      u_chk.end_test(4 * len);
   endtask

   initial begin
      int i;
      int len;
      repeat (4) @(negedge clk);
      rst = 1'b0;

      if (spi_ss !== 1'b1 || spi_sck !== 1'b0 || uart_tx !== 1'b1) begin
         errors++;
         $display("flash or uart pins were not idle after reset");
      end
      check_reg("ctrl after reset", reg_ctrl, 32'd0);
      wb_write(reg_addr, 32'h00AB_CDEF);
      wb_write(reg_len, 32'h0000_0003);
      wb_write(reg_baud, 32'h0000_0007);
      check_reg("addr readback", reg_addr, 32'h00AB_CDEF);
      check_reg("len readback", reg_len, 32'h0000_0003);
      check_reg("baud readback", reg_baud, 32'h0000_0007);

      run_dump("single word", 24'h10_0000, 1, 4, 1'b0);

      for (i = 0; i < 5; i++) begin
         rng = xorshift(rng);
         len = int'(rng[31:24] % 6) + 1;
         run_dump($sformatf("random dump %0d", i), rng[23:0], len, 4, 1'b0);
      end

      run_dump("baud 9", 24'h02_4680, 2, 9, 1'b0);
      run_dump("start while busy", 24'h7F_FFF0, 3, 4, 1'b1);

      u_chk.begin_test("zero length", 24'h00_0000, 4);
      wb_write(reg_len, 32'd0);
      wb_write(reg_ctrl, 32'd1);
      repeat (200) @(negedge clk);
      check_reg("zero length busy", reg_ctrl, 32'd0);
      u_chk.end_test(0);

      $display("errors: testbench %0d, checker %0d, flash model %0d", errors, u_chk.errors,
               u_flash.errors);
      if (errors + u_chk.errors + u_flash.errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: include/flash_ref.svh
function automatic logic [7:0] flash_byte(input logic [23:0] a);
   return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5A;   // address bytes folded with 0x5a
endfunction

// File: testbench/flash_dump_checker.sv
`timescale 1ns/1ns

module flash_dump_checker (
   input logic clk,
   input logic rst,
   input logic uart_line
);

   `include "flash_ref.svh"

   string       test_name = "none";
   logic [23:0] base      = '0;
   int          div       = 16;
   int          rx_count  = 0;
   int          errors    = 0;
   logic        prev_line = 1'b1;

   task automatic begin_test(input string name, input logic [23:0] b, input int d);
      test_name = name;
      base      = b;
      div       = d;
      rx_count  = 0;
   endtask

   task automatic end_test(input int expected);
      if (rx_count != expected) begin
         errors++;
         $display("%s: received %0d bytes but %0d were expected", test_name, rx_count,
                  expected);
      end
   endtask

   always begin : rx_frame
      int          k;
      int          d;
      int          rise;
      logic [9:0]  bits;
      logic [7:0]  exp_b;
      @(posedge clk);
      if (!rst && prev_line && !uart_line) begin
         d    = (div < 1) ? 1 : div;
         rise = 0;
         bits = '0;
         for (k = 0; k < 10 * d; k++) begin
            if (k > 0) @(posedge clk);
            if (k % d == d / 2) bits[k / d] = uart_line;   // mid bit
            if (uart_line && rise == 0) rise = k;
         end
         prev_line = uart_line;
         if (bits[0] != 1'b0 || bits[9] != 1'b1) begin
            errors++;
            $display("%s: framing error on byte %0d", test_name, rx_count);
         end
         // start bit length is visible when data bit 0 is high
         if (bits[1] && rise != d) begin
            errors++;
            $display("error %s bit period expected %0d actual %0d", test_name, d, rise);
         end
         exp_b = flash_byte(base + 24'(rx_count));
         if (bits[8:1] != exp_b) begin
            errors++;
            $display("error %s byte %0d expected %02h actual %02h", test_name, rx_count,
                     exp_b, bits[8:1]);
         end
         rx_count++;
      end else begin
         prev_line = uart_line;
      end
   end

endmodule

// File: testbench/spi_flash_model.sv
`timescale 1ns/1ns

module spi_flash_model (
   input  logic spi_sck,
   input  logic spi_ss,
   input  logic spi_mosi,
   output logic spi_miso
);

   `include "flash_ref.svh"

   logic [31:0] cmd_sh;
   logic [23:0] rd_addr;
   logic [7:0]  cur;
   int          bit_cnt = 0;
   int          bit_pos = 0;
   int          errors  = 0;

   initial spi_miso = 1'b0;

   always @(negedge spi_ss) begin
      bit_cnt = 0;
      bit_pos = 0;
   end

   // command and address sampled on the rising edge
   always @(posedge spi_sck) begin
      if (!spi_ss && bit_cnt < 32) begin
         cmd_sh = {cmd_sh[30:0], spi_mosi};
         bit_cnt++;
         if (bit_cnt == 32) begin
            rd_addr = cmd_sh[23:0];
            if (cmd_sh[31:24] != 8'h03) begin
               errors++;
               $display("flash model received opcode %h instead of a read", cmd_sh[31:24]);
            end
         end
      end
   end

   // data out on the falling edge msb first in address order
   always @(negedge spi_sck) begin
      if (!spi_ss && bit_cnt == 32) begin
         cur      = flash_byte(rd_addr);
         spi_miso = cur[7 - bit_pos];
         if (bit_pos == 7) begin
            bit_pos = 0;
            rd_addr = rd_addr + 1'b1;
         end else begin
            bit_pos++;
         end
      end
   end

endmodule

// File: logic/flash_dump.sv
`timescale 1ns/1ns

module flash_dump import dump_pkg::*; #(
   parameter int spi_div = 2
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [3:0]  wb_adr,
   input  logic [31:0] wb_dat_w,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack,
   output logic        spi_sck,
   output logic        spi_ss,
   output logic        spi_mosi,
   input  logic        spi_miso,
   output logic        uart_tx
);

   logic              start_pulse;
   logic [addr_w-1:0] start_addr;
   logic [len_w-1:0]  word_count;
   logic [baud_w-1:0] baud_div;
   logic              reader_busy;
   logic              done_pulse;
   logic [7:0]        tx_byte;
   logic              tx_start;
   logic              tx_busy;

   word_stream_if ws ();

   dump_regs u_regs (
      .clk(clk), .rst(rst),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .start_pulse(start_pulse), .start_addr(start_addr), .word_count(word_count),
      .baud_div(baud_div), .reader_busy(reader_busy), .done_pulse(done_pulse)
   );

   spi_flash_reader #(.spi_div(spi_div)) u_reader (
      .clk(clk), .rst(rst),
      .start_pulse(start_pulse), .start_addr(start_addr), .word_count(word_count),
      .busy(reader_busy),
      .spi_sck(spi_sck), .spi_ss(spi_ss), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
      .out_s(ws.source)
   );

   byte_sequencer u_seq (
      .clk(clk), .rst(rst),
      .in_s(ws.sink),
      .tx_byte(tx_byte), .tx_start(tx_start), .tx_busy(tx_busy),
      .done_pulse(done_pulse)
   );

   uart_tx u_tx (
      .clk(clk), .rst(rst),
      .baud_div(baud_div), .tx_byte(tx_byte), .tx_start(tx_start),
      .tx_busy(tx_busy), .uart_tx(uart_tx)
   );

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import dump_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic [baud_w-1:0] baud_div,
   input  logic [7:0]        tx_byte,
   input  logic              tx_start,
   output logic              tx_busy,
   output logic              uart_tx
);

   logic [baud_w-1:0] div_cnt;
   logic [3:0]        bit_idx;   // 0 start, 1..8 data, 9 stop
   logic [8:0]        sh;
   logic              bit_end;

   // a divisor of 0 behaves as 1
   assign bit_end = (({1'b0, div_cnt} + 1'b1) >= {1'b0, baud_div});

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_busy <= 1'b0;
         uart_tx <= 1'b1;
         div_cnt <= '0;
         bit_idx <= '0;
      end else if (!tx_busy) begin
         if (tx_start) begin
            sh      <= {1'b1, tx_byte};
            uart_tx <= 1'b0;          // start bit
            tx_busy <= 1'b1;
            div_cnt <= '0;
            bit_idx <= '0;
         end
      end else if (bit_end) begin
         div_cnt <= '0;
         if (bit_idx == 4'd9) begin
            tx_busy <= 1'b0;          // stop bit done
         end else begin
            uart_tx <= sh[0];
            sh      <= {1'b1, sh[8:1]};
            bit_idx <= bit_idx + 1'b1;
         end
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

endmodule

// File: logic/byte_sequencer.sv
`timescale 1ns/1ns

module byte_sequencer import dump_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   word_stream_if.sink in_s,
   output logic [7:0]  tx_byte,
   output logic        tx_start,
   input  logic        tx_busy,
   output logic        done_pulse
);

   logic [word_w-1:0] word;
   logic [1:0]        idx;       // next byte counted from the low end
   logic              full;
   logic              last_w;
   logic              wait_busy; // tx_busy rises a cycle after tx_start

   assign in_s.ready = ~full;

   always_ff @(posedge clk) begin
      if (rst) begin
         full       <= 1'b0;
         idx        <= '0;
         last_w     <= 1'b0;
         wait_busy  <= 1'b0;
         tx_start   <= 1'b0;
         done_pulse <= 1'b0;
      end else begin
         tx_start   <= 1'b0;
         done_pulse <= 1'b0;
         if (tx_busy) begin
            wait_busy <= 1'b0;
         end
         if (in_s.valid && !full) begin
            word   <= in_s.data;
            last_w <= in_s.last;
            idx    <= '0;
            full   <= 1'b1;
         end else if (full && !tx_busy && !wait_busy) begin
            tx_byte   <= word[{idx, 3'b000} +: 8];
            tx_start  <= 1'b1;
            wait_busy <= 1'b1;
            idx       <= idx + 1'b1;
            if (idx == 2'd3) begin
               full       <= 1'b0;
               done_pulse <= last_w;
            end
         end
      end
   end

endmodule

// File: logic/spi_flash_reader.sv
`timescale 1ns/1ns

module spi_flash_reader import dump_pkg::*; #(
   parameter int spi_div = 2
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              start_pulse,
   input  logic [addr_w-1:0] start_addr,
   input  logic [len_w-1:0]  word_count,
   output logic              busy,
   output logic              spi_sck,
   output logic              spi_ss,
   output logic              spi_mosi,
   input  logic              spi_miso,
   word_stream_if.source     out_s
);

   localparam int cnt_w = (spi_div > 1) ? $clog2(spi_div) : 1;

   typedef enum logic [2:0] {st_idle, st_cmd, st_addr, st_data, st_fin} state_t;

   state_t            state;
   logic [cnt_w-1:0]  div_cnt;
   logic              tick;
   logic              stall;
   logic              step;
   logic [4:0]        bit_cnt;
   logic [31:0]       tx_sh;
   logic [7:0]        rx_sh;
   logic [7:0]        rx_byte;
   logic [23:0]       rx_word;     // first three bytes of the word
   logic [len_w-1:0]  words_left;

   assign busy     = (state != st_idle);
   assign spi_mosi = tx_sh[31];
   assign tick     = (div_cnt == cnt_w'(spi_div - 1));
   assign rx_byte  = {rx_sh[6:0], spi_miso};

   // hold sck low before the last bit of a word while the stream slot is taken
   assign stall = (state == st_data) && !spi_sck && (bit_cnt == 5'd31) &&
                  out_s.valid && !out_s.ready;
   assign step  = tick && !stall;

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= st_idle;
         div_cnt     <= '0;
         spi_sck     <= 1'b0;
         spi_ss      <= 1'b1;
         bit_cnt     <= '0;
         tx_sh       <= '0;
         words_left  <= '0;
         out_s.valid <= 1'b0;
      end else begin
         if (out_s.valid && out_s.ready) begin
            out_s.valid <= 1'b0;
         end

         if (state == st_idle || step) begin
            div_cnt <= '0;
         end else if (!tick) begin
            div_cnt <= div_cnt + 1'b1;
         end

         case (state)
            st_idle: begin
               if (start_pulse) begin
                  tx_sh      <= {flash_cmd_read, start_addr};
                  words_left <= word_count;
                  bit_cnt    <= '0;
                  state      <= st_cmd;
               end
            end
            st_fin: begin
               if (step) begin
                  spi_ss <= 1'b1;
                  state  <= st_idle;
               end
            end
            default: begin
               if (step) begin
                  if (spi_ss) begin
                     spi_ss <= 1'b0;   // first command bit already on mosi
                  end else if (!spi_sck) begin
                     // rising edge samples miso
                     spi_sck <= 1'b1;
                     bit_cnt <= bit_cnt + 1'b1;
                     if (state == st_data) begin
                        rx_sh <= rx_byte;
                        if (bit_cnt[2:0] == 3'd7) begin
                           rx_word <= {rx_byte, rx_word[23:8]};   // little endian
                        end
                        if (bit_cnt == 5'd31) begin
                           out_s.data  <= {rx_byte, rx_word};
                           out_s.last  <= (words_left == len_w'(1));
                           out_s.valid <= 1'b1;
                           words_left  <= words_left - 1'b1;
                        end
                     end
                  end else begin
                     // falling edge shifts the next mosi bit
                     spi_sck <= 1'b0;
                     tx_sh   <= {tx_sh[30:0], 1'b0};
                     if (state == st_cmd && bit_cnt == 5'd8) begin
                        state <= st_addr;
                     end
                     if (state == st_addr && bit_cnt == 5'd0) begin
                        state <= st_data;
                     end
                     if (state == st_data && bit_cnt == 5'd0 && words_left == '0) begin
                        state <= st_fin;
                     end
                  end
               end
            end
         endcase
      end
   end

   sck_idle_low: assert property (@(posedge clk) disable iff (rst)
      spi_ss |-> !spi_sck);

endmodule

// File: logic/dump_regs.sv
`timescale 1ns/1ns

module dump_regs import dump_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              wb_cyc,
   input  logic              wb_stb,
   input  logic              wb_we,
   input  logic [3:0]        wb_adr,
   input  logic [31:0]       wb_dat_w,
   output logic [31:0]       wb_dat_r,
   output logic              wb_ack,
   output logic              start_pulse,
   output logic [addr_w-1:0] start_addr,
   output logic [len_w-1:0]  word_count,
   output logic [baud_w-1:0] baud_div,
   input  logic              reader_busy,
   input  logic              done_pulse
);

   logic req;
   logic busy;
   logic can_start;

   assign req = wb_cyc & wb_stb & ~wb_ack;  // ack drops while stb is still up
   assign can_start = ~busy & ~reader_busy & (word_count != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_ack      <= 1'b0;
         start_pulse <= 1'b0;
         busy        <= 1'b0;
         start_addr  <= '0;
         word_count  <= '0;
         baud_div    <= 16'd16;
      end else begin
         wb_ack      <= req;
         start_pulse <= 1'b0;
         if (req && wb_we) begin
            case (wb_adr)
               reg_ctrl: start_pulse <= wb_dat_w[0] & can_start;
               reg_addr: start_addr  <= wb_dat_w[addr_w-1:0];
               reg_len:  word_count  <= wb_dat_w[len_w-1:0];
               reg_baud: baud_div    <= wb_dat_w[baud_w-1:0];
               default: ;
            endcase
         end
         if (start_pulse) begin
            busy <= 1'b1;
         end else if (done_pulse) begin
            busy <= 1'b0;   // last byte handed to the uart
         end
      end
   end

   // read data valid on the ack cycle
   always_ff @(posedge clk) begin
      if (req) begin
         case (wb_adr)
            reg_ctrl: wb_dat_r <= {31'b0, busy};
            reg_addr: wb_dat_r <= 32'(start_addr);
            reg_len:  wb_dat_r <= 32'(word_count);
            reg_baud: wb_dat_r <= 32'(baud_div);
            default:  wb_dat_r <= '0;
         endcase
      end
   end

   start_taken: assert property (@(posedge clk) disable iff (rst)
      start_pulse |=> reader_busy);   // reader picks up every start

   done_in_dump: assert property (@(posedge clk) disable iff (rst)
      done_pulse |-> busy);   // no done outside a dump

endmodule

// File: logic/word_stream_if.sv
`timescale 1ns/1ns

interface word_stream_if import dump_pkg::*; ();

   logic              valid;
   logic              ready;
   logic [word_w-1:0] data;
   logic              last;   // final word of the dump

   modport source (
      output valid,
      output data,
      output last,
      input  ready
   );

   modport sink (
      input  valid,
      input  data,
      input  last,
      output ready
   );

endinterface

// File: logic/dump_pkg.sv
package dump_pkg;

   // stream and field widths
   localparam int word_w = 32;
   localparam int addr_w = 24;
   localparam int len_w  = 16;
   localparam int baud_w = 16;

   // wishbone byte offsets
   localparam logic [3:0] reg_ctrl = 4'h0;  // bit0 start on write, busy on read
   localparam logic [3:0] reg_addr = 4'h4;
   localparam logic [3:0] reg_len  = 4'h8;  // length in 32-bit words
   localparam logic [3:0] reg_baud = 4'hC;  // clk cycles per uart bit

   // standard serial flash read opcode
   localparam logic [7:0] flash_cmd_read = 8'h03;

endpackage
